// ==== common/isa_pkg.sv ====
////////////////////
// rv32 instruction word layouts
// one 32-bit word read through the r, i, s, b, u and j views
// plus the funct3 codes of the conditional branches
// import with isa_pkg::* in the module header
////////////////////
`default_nettype none

package isa_pkg;

	////////////////////
	// instruction views, msb first
	////////////////////
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;                      // register-register
		struct packed {
			logic [11:0] imm;     // imm[11:0]
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;                      // immediate, loads, jalr
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;                      // stores
		struct packed {
			logic       imm_12;   // sign bit
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;   // sits where rd[0] would be
			logic [6:0] opcode;
		} b;                      // conditional branches
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;                      // lui, auipc
		struct packed {
			logic       imm_20;   // sign bit
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;                      // jal
	} rv32_inst_t;

	// branch funct3, 3'b010 and 3'b011 reserved
	localparam logic [2:0] funct3_beq  = 3'b000;
	localparam logic [2:0] funct3_bne  = 3'b001;
	localparam logic [2:0] funct3_blt  = 3'b100;
	localparam logic [2:0] funct3_bge  = 3'b101;
	localparam logic [2:0] funct3_bltu = 3'b110;
	localparam logic [2:0] funct3_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== common/ex_pkg.sv ====
////////////////////
// execute stage constants
// word and tag widths, alu function codes,
// operand mux selects, multiplier timing
// import with ex_pkg::* in the module header
////////////////////
`default_nettype none

package ex_pkg;

	localparam int xlen      = 32;  // data word
	localparam int tag_width = 6;   // destination register tag

	////////////////////
	// multiplier timing
	////////////////////
	localparam int mult_bits_per_cycle = 8;                          // multiplier bits per step
	localparam int mult_latency        = xlen / mult_bits_per_cycle; // start to done, in cycles

	// alu function codes
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_slt    = 4'h2,
		alu_sltu   = 4'h3,
		alu_and    = 4'h4,
		alu_or     = 4'h5,
		alu_xor    = 4'h6,
		alu_sll    = 4'h7,
		alu_srl    = 4'h8,
		alu_sra    = 4'h9,
		alu_mul    = 4'ha,  // low half, signed x signed
		alu_mulh   = 4'hb,  // high half, signed x signed
		alu_mulhsu = 4'hc,  // high half, signed x unsigned
		alu_mulhu  = 4'hd   // high half, unsigned x unsigned
	} alu_func_t;

	// operand a sources
	typedef enum logic [1:0] {
		opa_rs1  = 2'h0,
		opa_npc  = 2'h1,  // pc + 4
		opa_pc   = 2'h2,
		opa_zero = 2'h3
	} opa_sel_t;

	// operand b sources, codes 6 and 7 unused
	typedef enum logic [2:0] {
		opb_rs2   = 3'h0,
		opb_i_imm = 3'h1,
		opb_s_imm = 3'h2,
		opb_b_imm = 3'h3,
		opb_u_imm = 3'h4,
		opb_j_imm = 3'h5
	} opb_sel_t;

endpackage

`default_nettype wire

// ==== hdl/operand_select.sv ====
////////////////////
// alu operand multiplexers
// a from rs1, pc + 4, pc or zero
// b from rs2 or a sign-extended immediate
// pulled out of the raw instruction word
// purely combinational
////////////////////
`timescale 1ns/10ps
`default_nettype none

module operand_select import isa_pkg::*, ex_pkg::*; (
	input  wire rv32_inst_t      inst,
	input  wire [xlen-1:0]       pc,
	input  wire [xlen-1:0]       rs1_value,
	input  wire [xlen-1:0]       rs2_value,
	input  wire opa_sel_t        opa_select,
	input  wire opb_sel_t        opb_select,
	output logic [xlen-1:0]      opa,
	output logic [xlen-1:0]      opb
);

	logic [xlen-1:0] npc;  // fall-through pc

	assign npc = pc + 32'd4;

	////////////////////
	// operand a
	////////////////////
	always_comb begin
		case (opa_select)
			opa_rs1:  opa = rs1_value;
			opa_npc:  opa = npc;
			opa_pc:   opa = pc;
			opa_zero: opa = '0;
			default:  opa = 32'hdeadfbac;  // filler, bad select
		endcase
	end

	////////////////////
	// operand b
	////////////////////
	always_comb begin
		case (opb_select)
			opb_rs2:   opb = rs2_value;
			opb_i_imm: opb = {{20{inst.i.imm[11]}}, inst.i.imm};
			opb_s_imm: opb = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
			// b and j immediates are halfword offsets, bit 0 always 0
			opb_b_imm: opb = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
			                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
			opb_u_imm: opb = {inst.u.imm_31_12, 12'b0};  // upper 20, low bits zero
			opb_j_imm: opb = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
			                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};
			default:   opb = 32'hfacefeed;  // recognizable on a waveform
		endcase
	end

endmodule

`default_nettype wire

// ==== alu/multiplier.sv ====
////////////////////
// iterative 32x32 multiplier, 64-bit product
// sign_mode[1] multiplicand signed, sign_mode[0] multiplier signed
// retires mult_bits_per_cycle multiplier bits per clock,
// done pulses mult_latency cycles after start
////////////////////
`timescale 1ns/10ps
`default_nettype none

module multiplier import ex_pkg::*; (
	input  wire              clock,
	input  wire              reset,
	input  wire              start,
	input  wire [1:0]        sign_mode,
	input  wire [xlen-1:0]   mcand,
	input  wire [xlen-1:0]   mplier,
	output logic [2*xlen-1:0] product,
	output logic             done
);

	logic [2*xlen-1:0]                 mcand_reg;   // shifts left each step
	logic [2*xlen-1:0]                 mplier_reg;  // shifts right each step
	logic [2*xlen-1:0]                 acc;
	logic [2*xlen-1:0]                 partial;
	logic signed [mult_bits_per_cycle:0] digit;     // one extra bit for sign
	logic [$clog2(mult_latency)-1:0]   step;
	logic                              busy;
	logic                              last_step;

	assign last_step = (step == mult_latency - 1);

	// top digit carries the multiplier sign, all others unsigned
	always_comb begin
		digit = {1'b0, mplier_reg[mult_bits_per_cycle-1:0]};
		if (last_step)
			digit[mult_bits_per_cycle] = mplier_reg[mult_bits_per_cycle];  // bit 32, the extension
	end

	assign partial = $signed(mcand_reg) * digit;  // mod 2^64

	////////////////////
	// step control
	////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					done <= 1'b1;  // acc final at this edge
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (start) begin
			mcand_reg  <= {{xlen{sign_mode[1] & mcand[xlen-1]}}, mcand};
			mplier_reg <= {{xlen{sign_mode[0] & mplier[xlen-1]}}, mplier};
			acc        <= '0;
		end else if (busy) begin
			acc        <= acc + partial;
			mcand_reg  <= mcand_reg << mult_bits_per_cycle;
			mplier_reg <= mplier_reg >> mult_bits_per_cycle;
		end
	end

	assign product = acc;  // held until next start

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
////////////////////
// integer alu with multiply sequencing
// logic and arithmetic pass straight through in the issue cycle
// a multiply starts the iterative multiplier and holds the
// stage occupied until the product comes back
////////////////////
`timescale 1ns/10ps
`default_nettype none

module alu import ex_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   valid_in,
	input  wire alu_func_t        func,
	input  wire [xlen-1:0]        opa,
	input  wire [xlen-1:0]        opb,
	input  wire                   branch_taken,
	input  wire [tag_width-1:0]   dest_tag_in,
	output logic                  occupied,
	output logic                  valid_out,
	output logic [xlen-1:0]       result,
	output logic                  take_branch,
	output logic [tag_width-1:0]  dest_tag_out
);

	typedef enum logic {st_idle, st_busy} alu_state_t;

	alu_state_t             state, next_state;
	logic                   is_mult;
	logic                   start;
	logic [1:0]             sign_mode;      // {mcand signed, mplier signed}
	logic                   high_half;      // want product[63:32]
	logic                   high_half_reg;
	logic [tag_width-1:0]   tag_reg;        // tag of multiply in flight
	logic [2*xlen-1:0]      product;
	logic                   mult_done;
	logic [xlen-1:0]        alu_result;

	assign is_mult = func inside {alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};

	multiplier mult_0 (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.sign_mode (sign_mode),
		.mcand     (opa),
		.mplier    (opb),
		.product   (product),
		.done      (mult_done)
	);

	////////////////////
	// combinational datapath
	////////////////////
	always_comb begin
		alu_result = '0;
		sign_mode  = 2'b00;
		high_half  = 1'b0;
		case (func)
			alu_add:    alu_result = opa + opb;  // wraps
			alu_sub:    alu_result = opa - opb;
			alu_slt:    alu_result = {31'b0, $signed(opa) < $signed(opb)};
			alu_sltu:   alu_result = {31'b0, opa < opb};
			alu_and:    alu_result = opa & opb;
			alu_or:     alu_result = opa | opb;
			alu_xor:    alu_result = opa ^ opb;
			alu_sll:    alu_result = opa << opb[4:0];
			alu_srl:    alu_result = opa >> opb[4:0];
			alu_sra:    alu_result = $signed(opa) >>> opb[4:0];  // sign fill
			alu_mul:    sign_mode  = 2'b11;
			alu_mulh:   begin
				sign_mode = 2'b11;
				high_half = 1'b1;
			end
			alu_mulhsu: begin
				sign_mode = 2'b10;  // rs1 signed, rs2 unsigned
				high_half = 1'b1;
			end
			alu_mulhu:  high_half = 1'b1;
			default:    alu_result = 32'hfacebeec;  // unused func code
		endcase
	end

	// idle/busy control
	always_comb begin
		next_state = state;
		start      = 1'b0;
		valid_out  = 1'b0;
		case (state)
			st_idle: if (valid_in) begin
				if (is_mult) begin
					start      = 1'b1;
					next_state = st_busy;
				end else
					valid_out = 1'b1;  // zero latency
			end
			st_busy: if (mult_done) begin
				valid_out  = 1'b1;
				next_state = st_idle;
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_ff @(posedge clock) begin
		if (start) begin
			high_half_reg <= high_half;  // capture context at acceptance
			tag_reg       <= dest_tag_in;
		end
	end

	////////////////////
	// output merge
	////////////////////
	assign occupied     = (state == st_busy);
	assign result       = occupied ? (high_half_reg ? product[2*xlen-1:xlen] : product[xlen-1:0])
	                               : alu_result;
	assign dest_tag_out = occupied ? tag_reg : dest_tag_in;
	assign take_branch  = occupied ? 1'b0 : branch_taken;  // a multiply never branches

endmodule

`default_nettype wire

// ==== hdl/branch_cond.sv ====
////////////////////
// conditional branch comparator
// funct3 from the b-format word picks the test
// reserved codes never take
////////////////////
`timescale 1ns/10ps
`default_nettype none

module branch_cond import isa_pkg::*, ex_pkg::*; (
	input  wire [xlen-1:0] rs1,
	input  wire [xlen-1:0] rs2,
	input  wire [2:0]      funct3,
	output logic           cond
);

	always_comb begin
		case (funct3)
			funct3_beq:  cond = (rs1 == rs2);
			funct3_bne:  cond = (rs1 != rs2);
			funct3_blt:  cond = ($signed(rs1) <  $signed(rs2));
			funct3_bge:  cond = ($signed(rs1) >= $signed(rs2));
			funct3_bltu: cond = (rs1 <  rs2);  // unsigned compare
			funct3_bgeu: cond = (rs1 >= rs2);
			default:     cond = 1'b0;          // 3'b010, 3'b011
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
////////////////////
// execute stage top
// operand muxes feed the alu, the comparator feeds the branch decision
// one instruction per valid_in strobe, none while occupied
////////////////////
`timescale 1ns/10ps
`default_nettype none

module ex_stage import isa_pkg::*, ex_pkg::*; (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   valid_in,
	input  wire rv32_inst_t       inst,
	input  wire [xlen-1:0]        pc,
	input  wire [xlen-1:0]        rs1_value,
	input  wire [xlen-1:0]        rs2_value,
	input  wire opa_sel_t         opa_select,
	input  wire opb_sel_t         opb_select,
	input  wire alu_func_t        alu_func,
	input  wire                   cond_branch,
	input  wire                   uncond_branch,
	input  wire [tag_width-1:0]   dest_tag_in,
	output logic                  valid_out,
	output logic [xlen-1:0]       result,
	output logic                  take_branch,
	output logic [tag_width-1:0]  dest_tag_out,
	output logic                  occupied
);

	logic [xlen-1:0] opa, opb;
	logic            cond;
	logic            branch_taken;

	operand_select operand_select_0 (
		.inst(inst), .pc(pc), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.opa_select(opa_select), .opb_select(opb_select), .opa(opa), .opb(opb)
	);

	branch_cond branch_cond_0 (
		.rs1(rs1_value), .rs2(rs2_value), .funct3(inst.b.funct3), .cond(cond)
	);

	// jumps always, branches on the compare
	assign branch_taken = uncond_branch | (cond_branch & cond);

	alu alu_0 (
		.clock(clock), .reset(reset), .valid_in(valid_in), .func(alu_func),
		.opa(opa), .opb(opb), .branch_taken(branch_taken), .dest_tag_in(dest_tag_in),
		.occupied(occupied), .valid_out(valid_out), .result(result),
		.take_branch(take_branch), .dest_tag_out(dest_tag_out)
	);

endmodule

`default_nettype wire

// ==== testbench/ex_stage_tb.sv ====
////////////////////
// testbench for the execute stage
// random non-multiply instructions checked in the issue cycle,
// multiplies checked at completion, busy cycles get junk input
// reference values come from the models below
////////////////////
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb import isa_pkg::*, ex_pkg::*; ();

	localparam int num_alu_ops    = 400;
	localparam int num_mult_ops   = 80;  // one after every fifth alu op
	localparam int timeout_cycles = (num_alu_ops + num_mult_ops) * (mult_latency + 2) + 50;

	logic                  clock, reset, valid_in;
	logic [31:0]           inst_word, pc, rs1_value, rs2_value;
	opa_sel_t              opa_select;
	opb_sel_t              opb_select;
	alu_func_t             alu_func;
	logic                  cond_branch, uncond_branch;
	logic [tag_width-1:0]  dest_tag_in;
	logic                  valid_out, take_branch, occupied;
	logic [xlen-1:0]       result;
	logic [tag_width-1:0]  dest_tag_out;
	logic [31:0]           seed;  // lcg state

	ex_stage DUT (
		.clock(clock), .reset(reset), .valid_in(valid_in), .inst(inst_word), .pc(pc),
		.rs1_value(rs1_value), .rs2_value(rs2_value), .opa_select(opa_select),
		.opb_select(opb_select), .alu_func(alu_func), .cond_branch(cond_branch),
		.uncond_branch(uncond_branch), .dest_tag_in(dest_tag_in), .valid_out(valid_out),
		.result(result), .take_branch(take_branch), .dest_tag_out(dest_tag_out),
		.occupied(occupied)
	);

	always #50 clock = ~clock;  // 100 ns period

	////////////////////
	// failure reporting
	////////////////////
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got, expected);
		abort_run($sformatf("mismatch %s: got %h expected %h", name, got, expected));
	endtask

	// random source
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] hi, lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};  // low lcg bits are weak
	endfunction

	////////////////////
	// reference model
	////////////////////
	function automatic logic [31:0] opa_model(input opa_sel_t sel, input logic [31:0] pc_v, rs1_v);
		case (sel)
			opa_rs1: return rs1_v;
			opa_npc: return pc_v + 32'd4;
			opa_pc:  return pc_v;
			default: return 32'd0;
		endcase
	endfunction

	// immediates straight from the raw bit positions of the word
	function automatic logic [31:0] opb_model(input opb_sel_t sel, input logic [31:0] w, rs2_v);
		case (sel)
			opb_rs2:   return rs2_v;
			opb_i_imm: return {{20{w[31]}}, w[31:20]};
			opb_s_imm: return {{20{w[31]}}, w[31:25], w[11:7]};
			opb_b_imm: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			opb_u_imm: return {w[31:12], 12'd0};
			opb_j_imm: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:   return 32'hfacefeed;
		endcase
	endfunction

	function automatic logic [31:0] alu_model(input alu_func_t f, input logic [31:0] a, b);
		logic [4:0] sh;
		sh = b[4:0];  // shift amount, low five bits only
		case (f)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			alu_sltu: return {31'd0, a < b};
			alu_and:  return a & b;
			alu_or:   return a | b;
			alu_xor:  return a ^ b;
			alu_sll:  return a << sh;
			alu_srl:  return a >> sh;
			alu_sra:  return (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
			default:  return 32'hx;
		endcase
	endfunction

	function automatic logic [31:0] mult_model(input alu_func_t f, input logic [31:0] a, b);
		logic [63:0] a64, b64, p;
		a64 = {{32{(f != alu_mulhu) & a[31]}}, a};                   // rs1 signed unless mulhu
		b64 = {{32{((f == alu_mul) || (f == alu_mulh)) & b[31]}}, b};
		p   = a64 * b64;  // mod 2^64 is enough
		return (f == alu_mul) ? p[31:0] : p[63:32];
	endfunction

	function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] x, y);
		logic lt_u, lt_s;
		lt_u = x < y;
		lt_s = (x[31] != y[31]) ? x[31] : lt_u;  // signs differ, negative one is less
		case (f3)
			funct3_beq:  return x == y;
			funct3_bne:  return !(x == y);
			funct3_blt:  return lt_s;
			funct3_bge:  return !lt_s;
			funct3_bltu: return lt_u;
			funct3_bgeu: return !lt_u;
			default:     return 1'b0;  // reserved
		endcase
	endfunction

	////////////////////
	// stimulus and checks
	////////////////////
	task automatic drive_random(input logic mult_op, input logic [1:0] mult_kind);
		logic [31:0] r;
		r          = random_word();
		inst_word  = random_word();
		pc         = random_word() & ~32'h3;
		rs1_value  = random_word();
		rs2_value  = (r[1:0] == 2'b00) ? rs1_value : random_word();  // equal a quarter of the time
		opa_select = opa_sel_t'(random_word() % 4);
		opb_select = opb_sel_t'(random_word() % 6);
		if (mult_op)
			alu_func = alu_func_t'(alu_mul + mult_kind);
		else
			alu_func = alu_func_t'(random_word() % 10);
		cond_branch   = r[2];
		uncond_branch = r[3] & r[4];  // jumps rarer than branches
		dest_tag_in   = r[10:5];
	endtask

	function automatic logic taken_model();
		return uncond_branch | (cond_branch & branch_model(inst_word[14:12], rs1_value, rs2_value));
	endfunction

	task automatic check_direct();
		logic [31:0] want;
		want = alu_model(alu_func, opa_model(opa_select, pc, rs1_value),
		                 opb_model(opb_select, inst_word, rs2_value));
		assert (valid_out === 1'b1) else report_mismatch("valid_out", valid_out, 1);
		assert (result === want) else report_mismatch("result", result, want);
		assert (take_branch === taken_model()) else
			report_mismatch("take_branch", take_branch, taken_model());
		assert (dest_tag_out === dest_tag_in) else
			report_mismatch("dest_tag_out", dest_tag_out, dest_tag_in);
		assert (occupied === 1'b0) else report_mismatch("occupied", occupied, 0);
	endtask

	task automatic run_multiply(input logic [1:0] kind);
		logic [31:0]          want, r;
		logic [tag_width-1:0] tag;
		drive_random(1'b1, kind);
		valid_in = 1'b1;
		want = mult_model(alu_func, opa_model(opa_select, pc, rs1_value),
		                  opb_model(opb_select, inst_word, rs2_value));
		tag  = dest_tag_in;  // must survive the wait
		@(negedge clock);
		assert (valid_out === 1'b0) else report_mismatch("valid_out", valid_out, 0);
		assert (occupied === 1'b0) else report_mismatch("occupied", occupied, 0);
		assert (take_branch === taken_model()) else
			report_mismatch("take_branch", take_branch, taken_model());
		for (int n = 0; n <= mult_latency; n++) begin
			@(posedge clock);  // n = 0 is the accepting edge
			#5;
			r = random_word();
			drive_random(r[0], r[2:1]);  // junk while busy
			valid_in = r[3];             // ignored strobes
			@(negedge clock);
			assert (occupied === 1'b1) else report_mismatch("occupied", occupied, 1);
			if (n < mult_latency) begin
				assert (valid_out === 1'b0) else report_mismatch("valid_out", valid_out, 0);
			end else begin
				assert (valid_out === 1'b1) else report_mismatch("valid_out", valid_out, 1);
				assert (result === want) else report_mismatch("result", result, want);
				assert (dest_tag_out === tag) else report_mismatch("dest_tag_out", dest_tag_out, tag);
				assert (take_branch === 1'b0) else report_mismatch("take_branch", take_branch, 0);
			end
		end
	endtask

	// watchdog
	initial begin
		#(timeout_cycles * 100);
		abort_run("timeout: the test sequence did not finish in time");
	end

	initial begin
		seed          = 32'hde63_d608;
		clock         = 1'b0;
		reset         = 1'b1;
		valid_in      = 1'b0;
		inst_word     = '0;
		pc            = '0;
		rs1_value     = '0;
		rs2_value     = '0;
		opa_select    = opa_rs1;
		opb_select    = opb_rs2;
		alu_func      = alu_add;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		dest_tag_in   = '0;
		repeat (4) @(posedge clock);
		#5;
		reset = 1'b0;
		repeat (2) begin  // quiet after reset
			@(negedge clock);
			assert (valid_out === 1'b0) else report_mismatch("valid_out", valid_out, 0);
			assert (occupied === 1'b0) else report_mismatch("occupied", occupied, 0);
		end
		for (int i = 0; i < num_alu_ops + num_mult_ops; i++) begin
			@(posedge clock);
			#5;
			if (i % 6 == 5) begin
				run_multiply(2'((i / 6) % 4));  // cycle through the four variants
			end else begin
				drive_random(1'b0, 2'd0);
				valid_in = 1'b1;
				@(negedge clock);
				check_direct();
			end
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
common/isa_pkg.sv
common/ex_pkg.sv
hdl/operand_select.sv
alu/multiplier.sv
alu/alu.sv
hdl/branch_cond.sv
hdl/ex_stage.sv
testbench/ex_stage_tb.sv
